// File: verilog.f
+incdir+src
src/aluPipePkg.sv
src/registerFile.sv
src/decodeStage.sv
src/executeStage.sv
src/aluPipeTop.sv
verif/clockGen.sv
verif/aluPipeTb.sv

// File: Makefile
# Verilator build and run for the ALU pipeline testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = aluPipeTb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) src/aluPipe_consts.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/aluPipeTb.sv
/*
 testbench for the three-stage ALU pipeline
 stimulus tasks, reference model of the register file and ALU
 retire checker against an expectation queue
 register load, forwarding, random mix, register 0, reset, illegal opcodes
 */
`include "aluPipe_consts.svh"

module aluPipeTb;

   timeunit 1ns;
   timeprecision 100ps;

   logic                    CLK;
   logic                    rst;
   logic                    instrValid;
   logic [`INSTR_WIDTH-1:0] instr;
   logic                    retireValid;
   aluPipePkg::regSel_t     retireDest;
   aluPipePkg::word_t       retireData;

   // model state and expected retires in issue order
   aluPipePkg::word_t   modelRegs [`REG_COUNT];
   aluPipePkg::regSel_t expDest [$];
   aluPipePkg::word_t   expData [$];
   int                  retired = 0;

   // random stimulus
   integer              seed;
   logic [31:0]         rnd;
   logic [31:0]         rnd2;
   int                  opIdx;
   int                  gap;
   aluPipePkg::aluOp_t  legalOps [11];

   clockGen clk0 (.CLK(CLK));

   aluPipeTop dut0 (
      .CLK         (CLK),
      .rst         (rst),
      .instrValid  (instrValid),
      .instr       (instr),
      .retireValid (retireValid),
      .retireDest  (retireDest),
      .retireData  (retireData)
   );

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic checkDest(input aluPipePkg::regSel_t got, input aluPipePkg::regSel_t exp);
      if (got !== exp) begin
         $display("[ERROR] retireDest: got 0x%h, expected 0x%h", got, exp);
         abortRun("retired destination differs from the model");
      end
   endtask

   task automatic checkData(input aluPipePkg::word_t got, input aluPipePkg::word_t exp);
      if (got !== exp) begin
         $display("[ERROR] retireData: got 0x%h, expected 0x%h", got, exp);
         abortRun("retired data differs from the model");
      end
   endtask

   // reference model with sequential semantics
   // one instruction at a time
   // returns 0 for an illegal opcode and leaves the model alone
   function automatic bit modelExec(input logic [`INSTR_WIDTH-1:0] ins,
                                    output aluPipePkg::regSel_t dest,
                                    output aluPipePkg::word_t data);
      logic [`OP_MSB-`OP_LSB:0]   opc;
      logic [`IMM_MSB-`IMM_LSB:0] imm;
      aluPipePkg::word_t          a;
      aluPipePkg::word_t          b;
      bit                         legal;
      opc   = ins[`OP_MSB:`OP_LSB];
      imm   = ins[`IMM_MSB:`IMM_LSB];
      dest  = ins[`RD_MSB:`RD_LSB];
      a     = modelRegs[ins[`RS_MSB:`RS_LSB]];
      b     = modelRegs[ins[`RT_MSB:`RT_LSB]];
      legal = 1'b1;
      data  = '0;
      case (opc)
         aluPipePkg::OP_ADD:  data = a + b;
         aluPipePkg::OP_SUB:  data = a - b;
         aluPipePkg::OP_AND:  data = a & b;
         aluPipePkg::OP_OR:   data = a | b;
         aluPipePkg::OP_XOR:  data = a ^ b;
         aluPipePkg::OP_SLL:  data = a << b[4:0];
         aluPipePkg::OP_SRL:  data = a >> b[4:0];
         aluPipePkg::OP_SLT:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         aluPipePkg::OP_ADDI: data = a + {{16{imm[15]}}, imm};
         aluPipePkg::OP_ORI:  data = a | {16'h0000, imm};
         aluPipePkg::OP_LUI:  data = {imm, 16'h0000};
         default:             legal = 1'b0;
      endcase
      // register 0 never changes
      if (legal && (dest != '0)) begin
         modelRegs[dest] = data;
      end
      return legal;
   endfunction

   function automatic logic [`INSTR_WIDTH-1:0] encodeI(input int opc, input int rd,
                                                       input int rs, input int imm);
      return {6'(opc), 5'(rd), 5'(rs), 16'(imm)};
   endfunction

   // rt lands in the top bits of the immediate field
   function automatic logic [`INSTR_WIDTH-1:0] encodeR(input int opc, input int rd,
                                                       input int rs, input int rt);
      return encodeI(opc, rd, rs, rt << `RT_LSB);
   endfunction

   task automatic clearModel();
      for (int i = 0; i < `REG_COUNT; i++) begin
         modelRegs[i] = '0;
      end
      expDest.delete();
      expData.delete();
   endtask

   // one instruction on the next rising edge
   task automatic issue(input logic [`INSTR_WIDTH-1:0] ins);
      aluPipePkg::regSel_t d;
      aluPipePkg::word_t   v;
      @(posedge CLK);
      instrValid <= 1'b1;
      instr      <= ins;
      if (modelExec(ins, d, v)) begin
         expDest.push_back(d);
         expData.push_back(v);
      end
   endtask

   task automatic idleCycles(input int n);
      repeat (n) begin
         @(posedge CLK);
         instrValid <= 1'b0;
      end
   endtask

   // wait until everything issued has retired or the limit runs out
   task automatic drainQueue(input int limit);
      int cycles;
      cycles = 0;
      idleCycles(1);
      while ((expDest.size() != 0) && (cycles < limit)) begin
         @(posedge CLK);
         cycles++;
      end
   endtask

   task automatic waitDrain(input int limit);
      drainQueue(limit);
      if (expDest.size() != 0) begin
         abortRun("timeout: no retire arrived for an issued instruction");
      end
   endtask

   // retire checker sampling on the falling edge
   always @(negedge CLK) begin
      if (retireValid === 1'b1) begin
         if (expDest.size() == 0) begin
            abortRun("unexpected retire with no instruction outstanding");
         end else begin
            checkDest(retireDest, expDest.pop_front());
            checkData(retireData, expData.pop_front());
            retired++;
         end
      end
   end

   initial begin
      seed       = 32'h388;
      rst        = 1'b1;
      instrValid = 1'b0;
      instr      = '0;
      legalOps   = '{aluPipePkg::OP_ADD, aluPipePkg::OP_SUB, aluPipePkg::OP_AND,
                     aluPipePkg::OP_OR, aluPipePkg::OP_XOR, aluPipePkg::OP_SLL,
                     aluPipePkg::OP_SRL, aluPipePkg::OP_SLT, aluPipePkg::OP_ADDI,
                     aluPipePkg::OP_ORI, aluPipePkg::OP_LUI};
      clearModel();
      repeat (10) @(posedge CLK);
      rst <= 1'b0;

      // distinct value per register
      // then read back back to back
      for (int i = 1; i < `REG_COUNT; i++) begin
         issue(encodeI(aluPipePkg::OP_ORI, i, 0, 16'h1000 + i * 16'h0111));
      end
      for (int i = 1; i < `REG_COUNT; i++) begin
         issue(encodeR(aluPipePkg::OP_OR, i, i, 0));
      end
      waitDrain(20);

      // dependent chains for forwarding at distance 1, 2 and 3
      // spacing adds idle cycles between the links
      for (int spacing = 0; spacing < 4; spacing++) begin
         issue(encodeI(aluPipePkg::OP_ADDI, 1, 0, 7 + spacing));
         idleCycles(spacing);
         issue(encodeR(aluPipePkg::OP_ADD, 2, 1, 1));
         idleCycles(spacing);
         issue(encodeR(aluPipePkg::OP_SUB, 3, 2, 1));
         idleCycles(spacing);
         issue(encodeR(aluPipePkg::OP_XOR, 4, 1, 3));
         issue(encodeR(aluPipePkg::OP_SLL, 5, 4, 1));
         waitDrain(20);
      end

      // full 32-bit random contents first
      for (int i = 1; i < `REG_COUNT; i++) begin
         rnd = $random(seed);
         issue(encodeI(aluPipePkg::OP_LUI, i, 0, int'(rnd[31:16])));
         issue(encodeI(aluPipePkg::OP_ORI, i, i, int'(rnd[15:0])));
      end
      // random mix of all legal opcodes with random idle gaps
      for (int n = 0; n < 300; n++) begin
         rnd   = $random(seed);
         rnd2  = $random(seed);
         opIdx = int'(rnd[7:0]) % 11;
         issue(encodeI(legalOps[opIdx], int'(rnd[12:8]), int'(rnd[17:13]),
                       int'(rnd2[15:0])));
         gap = int'(rnd[19:18]);
         if (gap == 3) begin
            gap = 0;
         end
         idleCycles(gap);
      end
      waitDrain(20);

      // a write to register 0 retires its value
      // reads of register 0 stay zero
      issue(encodeI(aluPipePkg::OP_ADDI, 0, 0, 16'h1234));
      issue(encodeR(aluPipePkg::OP_OR, 6, 0, 0));
      issue(encodeR(aluPipePkg::OP_ADD, 7, 0, 0));
      idleCycles(3);
      issue(encodeR(aluPipePkg::OP_OR, 8, 0, 0));
      waitDrain(20);

      // illegal codes vanish and later reads see the old values
      issue(encodeI(0, 9, 0, 16'hBEEF));
      issue(encodeR(aluPipePkg::OP_OR, 10, 9, 0));
      issue(encodeI(6'h3F, 10, 0, 16'h0001));
      issue(encodeI(6'h0C, 11, 9, 16'h0002));
      issue(encodeR(aluPipePkg::OP_ADD, 12, 10, 11));
      waitDrain(20);

      // reset with two instructions in flight
      // neither may retire
      issue(encodeI(aluPipePkg::OP_ADDI, 13, 0, 16'h0055));
      issue(encodeR(aluPipePkg::OP_ADD, 14, 13, 13));
      rst <= 1'b1;
      clearModel();
      idleCycles(3);
      rst <= 1'b0;
      for (int i = 1; i < `REG_COUNT; i++) begin
         issue(encodeR(aluPipePkg::OP_OR, i, i, 0));
      end
      drainQueue(40);

      $display("%0d instructions retired", retired);
      if (expDest.size() != 0) begin
         abortRun("timeout: no retire arrived for an issued instruction");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

// File: verif/clockGen.sv
/*
 testbench clock source
 free running clock, 4 ns period
 */
module clockGen (
   output logic CLK
);

   timeunit 1ns;
   timeprecision 100ps;

   // starts low, first rising edge at 2 ns
   initial begin
      CLK = 1'b0;
   end

   always begin
      #2 CLK = ~CLK;
   end

endmodule

// File: src/aluPipeTop.sv
/*
 top level of the three-stage ALU pipeline
 decode stage, execute stage and register file
 retire outputs double as the register file write
 */
`include "aluPipe_consts.svh"

module aluPipeTop (
   input  logic                    CLK,
   input  logic                    rst,
   input  logic                    instrValid,
   input  logic [`INSTR_WIDTH-1:0] instr,
   output logic                    retireValid,
   output aluPipePkg::regSel_t     retireDest,
   output aluPipePkg::word_t       retireData
);

   // register file read ports
   aluPipePkg::regSel_t rsel1;
   aluPipePkg::regSel_t rsel2;
   aluPipePkg::word_t   rdat1;
   aluPipePkg::word_t   rdat2;

   // decode to execute
   logic                opValid;
   aluPipePkg::aluOp_t  op;
   aluPipePkg::word_t   opA;
   aluPipePkg::word_t   opB;
   aluPipePkg::regSel_t opDest;

   // execute back to decode for forwarding
   aluPipePkg::word_t   aluResult;

   decodeStage decode0 (
      .CLK         (CLK),
      .rst         (rst),
      .instrValid  (instrValid),
      .instr       (instr),
      .rdat1       (rdat1),
      .rdat2       (rdat2),
      .aluResult   (aluResult),
      .retireValid (retireValid),
      .retireDest  (retireDest),
      .retireData  (retireData),
      .rsel1       (rsel1),
      .rsel2       (rsel2),
      .opValid     (opValid),
      .op          (op),
      .opA         (opA),
      .opB         (opB),
      .opDest      (opDest)
   );

   executeStage execute0 (
      .CLK         (CLK),
      .rst         (rst),
      .opValid     (opValid),
      .op          (op),
      .opA         (opA),
      .opB         (opB),
      .opDest      (opDest),
      .aluResult   (aluResult),
      .retireValid (retireValid),
      .retireDest  (retireDest),
      .retireData  (retireData)
   );

   // write port straight from the retire register
   registerFile regFile0 (
      .CLK   (CLK),
      .rst   (rst),
      .wen   (retireValid),
      .wsel  (retireDest),
      .wdat  (retireData),
      .rsel1 (rsel1),
      .rsel2 (rsel2),
      .rdat1 (rdat1),
      .rdat2 (rdat2)
   );

endmodule

// File: src/executeStage.sv
/*
 execute stage of the ALU pipeline
 combinational ALU over the decoded operands
 result register feeding retire and the register file write
 */
`include "aluPipe_consts.svh"

module executeStage (
   input  logic                CLK,
   input  logic                rst,
   input  logic                opValid,
   input  aluPipePkg::aluOp_t  op,
   input  aluPipePkg::word_t   opA,
   input  aluPipePkg::word_t   opB,
   input  aluPipePkg::regSel_t opDest,
   output aluPipePkg::word_t   aluResult,
   output logic                retireValid,
   output aluPipePkg::regSel_t retireDest,
   output aluPipePkg::word_t   retireData
);

   // shift amount width for a data word
   localparam int shamtBits = $clog2(`DATA_WIDTH);

   logic [shamtBits-1:0] shamt;

   assign shamt = opB[shamtBits-1:0];

   // ALU, immediates already sit in opB
   always_comb begin
      case (op)
         aluPipePkg::OP_ADD:  aluResult = opA + opB;
         aluPipePkg::OP_SUB:  aluResult = opA - opB;
         aluPipePkg::OP_AND:  aluResult = opA & opB;
         aluPipePkg::OP_OR:   aluResult = opA | opB;
         aluPipePkg::OP_XOR:  aluResult = opA ^ opB;
         aluPipePkg::OP_SLL:  aluResult = opA << shamt;
         aluPipePkg::OP_SRL:  aluResult = opA >> shamt;
         // signed compare
         aluPipePkg::OP_SLT: begin
            if ($signed(opA) < $signed(opB)) begin
               aluResult = `DATA_WIDTH'(1);
            end else begin
               aluResult = '0;
            end
         end
         aluPipePkg::OP_ADDI: aluResult = opA + opB;
         aluPipePkg::OP_ORI:  aluResult = opA | opB;
         // upper immediate passes through
         aluPipePkg::OP_LUI:  aluResult = opB;
         // unreachable, decode drops illegal codes
         default:             aluResult = '0;
      endcase
   end

   // retire strobe
   // cleared on reset so nothing in flight retires
   always_ff @(posedge CLK) begin
      if (rst) begin
         retireValid <= 1'b0;
      end else begin
         retireValid <= opValid;
      end
   end

   // result register, also the register file write port
   always_ff @(posedge CLK) begin
      if (opValid) begin
         retireDest <= opDest;
         retireData <= aluResult;
      end
   end

endmodule

// File: src/decodeStage.sv
/*
 decode stage of the ALU pipeline
 field split, register file read selects
 operand forwarding from execute and retire
 immediate selection, opcode check, stage registers
 */
`include "aluPipe_consts.svh"

module decodeStage (
   input  logic                     CLK,
   input  logic                     rst,
   input  logic                     instrValid,
   input  logic [`INSTR_WIDTH-1:0]  instr,
   input  aluPipePkg::word_t        rdat1,
   input  aluPipePkg::word_t        rdat2,
   input  aluPipePkg::word_t        aluResult,
   input  logic                     retireValid,
   input  aluPipePkg::regSel_t      retireDest,
   input  aluPipePkg::word_t        retireData,
   output aluPipePkg::regSel_t      rsel1,
   output aluPipePkg::regSel_t      rsel2,
   output logic                     opValid,
   output aluPipePkg::aluOp_t       op,
   output aluPipePkg::word_t        opA,
   output aluPipePkg::word_t        opB,
   output aluPipePkg::regSel_t      opDest
);

   localparam int immBits = `IMM_MSB - `IMM_LSB + 1;

   // instruction fields
   aluPipePkg::aluOp_t  opCode;
   aluPipePkg::regSel_t fieldRd;
   aluPipePkg::regSel_t fieldRs;
   aluPipePkg::regSel_t fieldRt;
   logic [immBits-1:0]  fieldImm;

   // resolved operands
   logic                opLegal;
   aluPipePkg::word_t   srcA;
   aluPipePkg::word_t   srcB;
   aluPipePkg::word_t   nextB;

   assign opCode   = aluPipePkg::aluOp_t'(instr[`OP_MSB:`OP_LSB]);
   assign fieldRd  = instr[`RD_MSB:`RD_LSB];
   assign fieldRs  = instr[`RS_MSB:`RS_LSB];
   assign fieldRt  = instr[`RT_MSB:`RT_LSB];
   assign fieldImm = instr[`IMM_MSB:`IMM_LSB];

   // register file reads straight from the fields
   assign rsel1 = fieldRs;
   assign rsel2 = fieldRt;

   // youngest producer wins
   // execute first, then the retiring result, then the register file
   // register 0 is never forwarded
   function automatic aluPipePkg::word_t forward(
      input aluPipePkg::regSel_t sel,
      input aluPipePkg::word_t   fileVal
   );
      aluPipePkg::word_t val;
      val = fileVal;
      if (sel != '0) begin
         if (opValid && (opDest == sel)) begin
            val = aluResult;
         end else if (retireValid && (retireDest == sel)) begin
            val = retireData;
         end
      end
      return val;
   endfunction

   always_comb begin
      srcA = forward(fieldRs, rdat1);
      srcB = forward(fieldRt, rdat2);
   end

   // second operand, immediates replace the rt value
   always_comb begin
      case (opCode)
         // sign extended
         aluPipePkg::OP_ADDI: nextB = {{(`DATA_WIDTH-immBits){fieldImm[immBits-1]}}, fieldImm};
         // zero extended
         aluPipePkg::OP_ORI:  nextB = {{(`DATA_WIDTH-immBits){1'b0}}, fieldImm};
         // upper half, zeros below
         aluPipePkg::OP_LUI:  nextB = {fieldImm, {(`DATA_WIDTH-immBits){1'b0}}};
         default:             nextB = srcB;
      endcase
   end

   // legal opcode check
   always_comb begin
      case (opCode)
         aluPipePkg::OP_ADD,
         aluPipePkg::OP_SUB,
         aluPipePkg::OP_AND,
         aluPipePkg::OP_OR,
         aluPipePkg::OP_XOR,
         aluPipePkg::OP_SLL,
         aluPipePkg::OP_SRL,
         aluPipePkg::OP_SLT,
         aluPipePkg::OP_ADDI,
         aluPipePkg::OP_ORI,
         aluPipePkg::OP_LUI: opLegal = 1'b1;
         default:            opLegal = 1'b0;
      endcase
   end

   // stage valid, illegal ops simply vanish here
   always_ff @(posedge CLK) begin
      if (rst) begin
         opValid <= 1'b0;
      end else begin
         opValid <= instrValid && opLegal;
      end
   end

   // stage payload, loaded with each strobe
   always_ff @(posedge CLK) begin
      if (instrValid) begin
         op     <= opCode;
         opA    <= srcA;
         opB    <= nextB;
         opDest <= fieldRd;
      end
   end

endmodule

// File: src/registerFile.sv
/*
 register file, 32 words of 32 bits
 two combinational read ports, one write port at the clock edge
 register 0 reads as zero, synchronous clear of every word
 */
`include "aluPipe_consts.svh"

module registerFile (
   input  logic                CLK,
   input  logic                rst,
   input  logic                wen,
   input  aluPipePkg::regSel_t wsel,
   input  aluPipePkg::word_t   wdat,
   input  aluPipePkg::regSel_t rsel1,
   input  aluPipePkg::regSel_t rsel2,
   output aluPipePkg::word_t   rdat1,
   output aluPipePkg::word_t   rdat2
);

   // storage
   aluPipePkg::word_t regs [`REG_COUNT];

   // clear everything on reset
   // writes to register 0 are ignored
   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && (wsel != '0)) begin
         regs[wsel] <= wdat;
      end
   end

   // read ports, no write bypass
   // a read in the write cycle still sees the old word
   always_comb begin
      if (rsel1 == '0) begin
         rdat1 = '0;
      end else begin
         rdat1 = regs[rsel1];
      end
   end

   always_comb begin
      if (rsel2 == '0) begin
         rdat2 = '0;
      end else begin
         rdat2 = regs[rsel2];
      end
   end

endmodule

// File: src/aluPipePkg.sv
/*
 shared types for the ALU pipeline
 opcode enum, register selector and data word
 */
`include "aluPipe_consts.svh"

package aluPipePkg;

   // opcode field, 6 bits wide
   // anything not listed here is illegal and gets dropped in decode
   typedef enum logic [`OP_MSB-`OP_LSB:0] {
      // register with register
      OP_ADD  = 6'h01,
      OP_SUB  = 6'h02,
      OP_AND  = 6'h03,
      OP_OR   = 6'h04,
      OP_XOR  = 6'h05,
      // shift amount from low bits of second source
      OP_SLL  = 6'h06,
      OP_SRL  = 6'h07,
      // signed compare, result is 1 or 0
      OP_SLT  = 6'h08,
      // immediate forms
      OP_ADDI = 6'h09,
      OP_ORI  = 6'h0A,
      OP_LUI  = 6'h0B
   } aluOp_t;

   // register selector
   typedef logic [`REG_SEL_WIDTH-1:0] regSel_t;

   // data word
   typedef logic [`DATA_WIDTH-1:0] word_t;

endpackage

// File: src/aluPipe_consts.svh
/*
 width and field layout macros for the three-stage ALU pipeline
 data, register count and register selector widths
 instruction width and bit positions of every field
 */
`ifndef ALUPIPE_CONSTS_SVH
`define ALUPIPE_CONSTS_SVH

// datapath sizes
`define DATA_WIDTH    32
`define REG_COUNT     32
`define REG_SEL_WIDTH 5
`define INSTR_WIDTH   32

// opcode, bits 31 to 26
`define OP_MSB  31
`define OP_LSB  26
// destination register
`define RD_MSB  25
`define RD_LSB  21
// first source
`define RS_MSB  20
`define RS_LSB  16
// second source, overlaps the immediate
`define RT_MSB  15
`define RT_LSB  11
`define IMM_MSB 15
`define IMM_LSB 0

`endif
